/* include/mips_cfg.svh */
`ifndef MIPS_CFG_SVH
`define MIPS_CFG_SVH

// datapath widths
`define MIPS_XLEN      32
`define MIPS_RA_W      5
`define MIPS_RESET_PC  32'h0000_0000
`define MIPS_PC_STEP   32'd4

// opcodes, bits 31:26
`define MIPS_OP_RTYPE  6'b000000
`define MIPS_OP_LW     6'b100011
`define MIPS_OP_SW     6'b101011
`define MIPS_OP_BEQ    6'b000100
`define MIPS_OP_BNE    6'b000101
`define MIPS_OP_ADDI   6'b001000
`define MIPS_OP_ADDIU  6'b001001

// funct codes for r-type, bits 5:0
`define MIPS_FN_ADD    6'b100000
`define MIPS_FN_ADDU   6'b100001
`define MIPS_FN_SUB    6'b100010
`define MIPS_FN_SUBU   6'b100011
`define MIPS_FN_AND    6'b100100
`define MIPS_FN_OR     6'b100101
`define MIPS_FN_SLT    6'b101010
`define MIPS_FN_SLTU   6'b101011

// alu control codes
`define MIPS_ALU_AND   4'b0000
`define MIPS_ALU_OR    4'b0001
`define MIPS_ALU_ADD   4'b0010
`define MIPS_ALU_SUB   4'b0110
`define MIPS_ALU_SLT   4'b0111
`define MIPS_ALU_SLTU  4'b1111

// alu op class from the main decoder
`define MIPS_ACLS_ADD  3'b000
`define MIPS_ACLS_SUB  3'b001
`define MIPS_ACLS_RTYPE 3'b111

`endif

/* hw/mips_pkg.sv */
`default_nettype none

`include "mips_cfg.svh"

package mips_pkg;

  // ----------------------------------------------------------------------
  // alu and forwarding encodings
  // ----------------------------------------------------------------------
  typedef enum logic [3:0] {
    alu_and  = `MIPS_ALU_AND,
    alu_or   = `MIPS_ALU_OR,
    alu_add  = `MIPS_ALU_ADD,
    alu_sub  = `MIPS_ALU_SUB,
    alu_slt  = `MIPS_ALU_SLT,
    alu_sltu = `MIPS_ALU_SLTU
  } alu_op_t;

  typedef enum logic [1:0] {
    fwd_reg = 2'b00,                      // value read in decode
    fwd_wb  = 2'b01,                      // writeback result
    fwd_mem = 2'b10                       // alu result sitting in memory stage
  } fwd_sel_t;

  // decoded control, all zero is a nop
  typedef struct packed {
    logic       regwrite;
    logic       regdst;                   // 1 writes rd, 0 writes rt
    logic       alusrc;                   // 1 takes the immediate as b
    logic       branch;
    logic       bne;                      // inverts the zero test
    logic       memread;
    logic       memwrite;
    logic       memtoreg;
    logic [2:0] alu_class;
  } ctrl_t;

  // ----------------------------------------------------------------------
  // stage payloads
  // ----------------------------------------------------------------------
  typedef struct packed {
    logic [`MIPS_XLEN-1:0] instr;
    logic [`MIPS_XLEN-1:0] pcplus4;
  } ifid_t;

  typedef struct packed {
    ctrl_t                 ctrl;
    logic [5:0]            funct;         // alu decode happens in execute
    logic [`MIPS_XLEN-1:0] pcplus4;
    logic [`MIPS_XLEN-1:0] srca;
    logic [`MIPS_XLEN-1:0] srcb;
    logic [`MIPS_XLEN-1:0] imm;           // sign-extended
    logic [`MIPS_RA_W-1:0] rs;
    logic [`MIPS_RA_W-1:0] rt;
    logic [`MIPS_RA_W-1:0] rd;
  } idex_t;

  typedef struct packed {
    logic                  regwrite;
    logic                  memread;
    logic                  memwrite;
    logic                  memtoreg;
    logic [`MIPS_XLEN-1:0] aluout;
    logic [`MIPS_XLEN-1:0] writedata;     // store data after forwarding
    logic [`MIPS_RA_W-1:0] writereg;
  } exmem_t;

  typedef struct packed {
    logic                  regwrite;
    logic                  memtoreg;
    logic [`MIPS_XLEN-1:0] readdata;
    logic [`MIPS_XLEN-1:0] aluout;
    logic [`MIPS_RA_W-1:0] writereg;
  } memwb_t;

endpackage

`default_nettype wire

/* hw/mips_decoder.sv */
`timescale 1ns/1ns
`default_nettype none

`include "mips_cfg.svh"

module mips_decoder (
  input  logic [5:0]        op,           // decode-stage opcode
  input  logic [5:0]        ex_funct,     // execute-stage funct
  input  logic [2:0]        ex_alu_class,
  output mips_pkg::ctrl_t   ctrl,
  output mips_pkg::alu_op_t alu_op
);

  // ----------------------------------------------------------------------
  // main decoder, decode stage
  // ----------------------------------------------------------------------
  always_comb
  begin
    ctrl = '0;                            // unknown opcodes fall through as nop
    case (op)
      `MIPS_OP_RTYPE:
      begin
        ctrl.regwrite  = 1'b1;
        ctrl.regdst    = 1'b1;
        ctrl.alu_class = `MIPS_ACLS_RTYPE;
      end
      `MIPS_OP_LW:
      begin
        ctrl.regwrite  = 1'b1;
        ctrl.alusrc    = 1'b1;
        ctrl.memread   = 1'b1;
        ctrl.memtoreg  = 1'b1;
        ctrl.alu_class = `MIPS_ACLS_ADD;  // base + offset
      end
      `MIPS_OP_SW:
      begin
        ctrl.alusrc    = 1'b1;
        ctrl.memwrite  = 1'b1;
        ctrl.alu_class = `MIPS_ACLS_ADD;
      end
      `MIPS_OP_BEQ:
      begin
        ctrl.branch    = 1'b1;
        ctrl.alu_class = `MIPS_ACLS_SUB;  // compare by subtracting
      end
      `MIPS_OP_BNE:
      begin
        ctrl.branch    = 1'b1;
        ctrl.bne       = 1'b1;
        ctrl.alu_class = `MIPS_ACLS_SUB;
      end
      `MIPS_OP_ADDI,
      `MIPS_OP_ADDIU:                     // no overflow trap, so same as addi
      begin
        ctrl.regwrite  = 1'b1;
        ctrl.alusrc    = 1'b1;
        ctrl.alu_class = `MIPS_ACLS_ADD;
      end
      default:
      begin
        ctrl = '0;
      end
    endcase
  end

  // ----------------------------------------------------------------------
  // alu decoder, execute stage
  // ----------------------------------------------------------------------
  always_comb
  begin
    case (ex_alu_class)
      `MIPS_ACLS_ADD: alu_op = mips_pkg::alu_add;
      `MIPS_ACLS_SUB: alu_op = mips_pkg::alu_sub;
      default:
      begin
        case (ex_funct)                   // r-type table
          `MIPS_FN_ADD,
          `MIPS_FN_ADDU: alu_op = mips_pkg::alu_add;
          `MIPS_FN_SUB,
          `MIPS_FN_SUBU: alu_op = mips_pkg::alu_sub;
          `MIPS_FN_AND:  alu_op = mips_pkg::alu_and;
          `MIPS_FN_OR:   alu_op = mips_pkg::alu_or;
          `MIPS_FN_SLT:  alu_op = mips_pkg::alu_slt;
          `MIPS_FN_SLTU: alu_op = mips_pkg::alu_sltu;
          default:       alu_op = mips_pkg::alu_add;  // sll 0 nop lands here
        endcase
      end
    endcase
  end

endmodule

`default_nettype wire

/* hw/regfile.sv */
`timescale 1ns/1ns
`default_nettype none

`include "mips_cfg.svh"

module regfile (
  input  logic                  clk,
  input  logic                  we,
  input  logic [`MIPS_RA_W-1:0] ra1,
  input  logic [`MIPS_RA_W-1:0] ra2,
  input  logic [`MIPS_RA_W-1:0] wa,
  input  logic [`MIPS_XLEN-1:0] wd,
  output logic [`MIPS_XLEN-1:0] rd1,
  output logic [`MIPS_XLEN-1:0] rd2
);

  logic [`MIPS_XLEN-1:0] rf [0:(1<<`MIPS_RA_W)-1];

  // write on the rising edge, $0 never stored
  always_ff @(posedge clk)
  begin
    if (we && (wa != '0))
    begin
      rf[wa] <= wd;
    end
  end

  // combinational reads, $0 hardwired
  assign rd1 = (ra1 == '0) ? '0 : rf[ra1];
  assign rd2 = (ra2 == '0) ? '0 : rf[ra2];

endmodule

`default_nettype wire

/* hw/alu.sv */
`timescale 1ns/1ns
`default_nettype none

`include "mips_cfg.svh"

module alu (
  input  logic [`MIPS_XLEN-1:0] a,
  input  logic [`MIPS_XLEN-1:0] b,
  input  mips_pkg::alu_op_t     op,
  output logic [`MIPS_XLEN-1:0] result,
  output logic                  zero
);

  logic [`MIPS_XLEN-1:0] diff;            // shared by sub and both compares

  assign diff = a - b;

  always_comb
  begin
    case (op)
      mips_pkg::alu_and:  result = a & b;
      mips_pkg::alu_or:   result = a | b;
      mips_pkg::alu_add:  result = a + b;
      mips_pkg::alu_sub:  result = diff;
      mips_pkg::alu_slt:
      begin
        // signed: sign of a-b, corrected when the subtraction overflows
        result = {{(`MIPS_XLEN-1){1'b0}},
                  (a[`MIPS_XLEN-1] != b[`MIPS_XLEN-1]) ? a[`MIPS_XLEN-1]
                                                       : diff[`MIPS_XLEN-1]};
      end
      mips_pkg::alu_sltu: result = {{(`MIPS_XLEN-1){1'b0}}, (a < b)};
      default:            result = a + b;
    endcase
  end

  assign zero = (result == '0);           // beq/bne test after sub

endmodule

`default_nettype wire

/* hw/hazard_unit.sv */
`timescale 1ns/1ns
`default_nettype none

`include "mips_cfg.svh"

module hazard_unit (
  input  logic [`MIPS_RA_W-1:0] id_rs,
  input  logic [`MIPS_RA_W-1:0] id_rt,
  input  logic [`MIPS_RA_W-1:0] ex_rs,
  input  logic [`MIPS_RA_W-1:0] ex_rt,
  input  logic                  ex_memread,
  input  logic                  ex_branch_taken,
  input  logic [`MIPS_RA_W-1:0] mem_rd,
  input  logic                  mem_regwrite,
  input  logic [`MIPS_RA_W-1:0] wb_rd,
  input  logic                  wb_regwrite,
  output mips_pkg::fwd_sel_t    fwd_a,
  output mips_pkg::fwd_sel_t    fwd_b,
  output logic                  id_fwd_a,
  output logic                  id_fwd_b,
  output logic                  stall,
  output logic                  flush
);

  logic mem_hit_a, mem_hit_b;
  logic wb_hit_a, wb_hit_b;

  // ----------------------------------------------------------------------
  // execute operand forwarding
  // ----------------------------------------------------------------------
  assign mem_hit_a = mem_regwrite && (ex_rs != '0) && (mem_rd == ex_rs);
  assign mem_hit_b = mem_regwrite && (ex_rt != '0) && (mem_rd == ex_rt);
  assign wb_hit_a  = wb_regwrite  && (ex_rs != '0) && (wb_rd  == ex_rs);
  assign wb_hit_b  = wb_regwrite  && (ex_rt != '0) && (wb_rd  == ex_rt);

  always_comb
  begin
    // newest producer wins
    if (mem_hit_a)
      fwd_a = mips_pkg::fwd_mem;
    else if (wb_hit_a)
      fwd_a = mips_pkg::fwd_wb;
    else
      fwd_a = mips_pkg::fwd_reg;

    if (mem_hit_b)
      fwd_b = mips_pkg::fwd_mem;
    else if (wb_hit_b)
      fwd_b = mips_pkg::fwd_wb;
    else
      fwd_b = mips_pkg::fwd_reg;
  end

  // decode read bypass, covers the write landing in the same cycle
  assign id_fwd_a = wb_regwrite && (id_rs != '0) && (wb_rd == id_rs);
  assign id_fwd_b = wb_regwrite && (id_rt != '0) && (wb_rd == id_rt);

  // ----------------------------------------------------------------------
  // stall and flush
  // ----------------------------------------------------------------------
  // load in execute, consumer in decode: one bubble
  assign stall = ex_memread && (ex_rt != '0) &&
                 ((ex_rt == id_rs) || (ex_rt == id_rt));

  assign flush = ex_branch_taken;         // kills decode and fetch

endmodule

`default_nettype wire

/* hw/pipe_reg.sv */
`timescale 1ns/1ns
`default_nettype none

module pipe_reg #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     reset,
  input  logic     hold,                  // keep current payload
  input  logic     clear,                 // load a bubble, beats hold
  input  payload_t d,
  output payload_t q
);

  // zero payload means every control bit low, so a nop
  always_ff @(posedge clk)
  begin
    if (reset || clear)
    begin
      q <= '0;
    end
    else if (!hold)
    begin
      q <= d;
    end
  end

endmodule

`default_nettype wire

/* hw/mips_pipeline.sv */
`timescale 1ns/1ns
`default_nettype none

`include "mips_cfg.svh"

module mips_pipeline (
  input  logic                  clk,
  input  logic                  reset,
  output logic [`MIPS_XLEN-1:0] pc,
  input  logic [`MIPS_XLEN-1:0] instr,
  output logic                  memwrite,
  output logic [`MIPS_XLEN-1:0] memaddr,
  output logic [`MIPS_XLEN-1:0] memwritedata,
  input  logic [`MIPS_XLEN-1:0] memreaddata
);

  mips_pkg::ifid_t    ifid_d, ifid_q;
  mips_pkg::idex_t    idex_d, idex_q;
  mips_pkg::exmem_t   exmem_d, exmem_q;
  mips_pkg::memwb_t   memwb_d, memwb_q;
  mips_pkg::ctrl_t    id_ctrl;
  mips_pkg::alu_op_t  ex_alu_op;
  mips_pkg::fwd_sel_t fwd_a, fwd_b;

  logic [`MIPS_XLEN-1:0] pcplus4, pc_next;
  logic [`MIPS_XLEN-1:0] id_rd1, id_rd2;
  logic [`MIPS_XLEN-1:0] ex_opa, ex_opb, ex_srcb, ex_result, ex_target;
  logic [`MIPS_XLEN-1:0] wb_result;
  logic [`MIPS_RA_W-1:0] ex_writereg;
  logic                  ex_zero, ex_taken;
  logic                  id_fwd_a, id_fwd_b;
  logic                  stall, flush;

  // ----------------------------------------------------------------------
  // fetch
  // ----------------------------------------------------------------------
  assign pcplus4 = pc + `MIPS_PC_STEP;
  assign pc_next = flush ? ex_target : pcplus4;  // taken branch redirects

  always_ff @(posedge clk)
  begin
    if (reset)
      pc <= `MIPS_RESET_PC;
    else if (!stall)                      // load-use repeats the fetch
      pc <= pc_next;
  end

  always_comb
  begin
    ifid_d.instr   = instr;
    ifid_d.pcplus4 = pcplus4;
  end

  pipe_reg #(.payload_t(mips_pkg::ifid_t)) u_ifid (
    .clk(clk), .reset(reset), .hold(stall), .clear(flush), .d(ifid_d), .q(ifid_q)
  );

  // ----------------------------------------------------------------------
  // decode
  // ----------------------------------------------------------------------
  mips_decoder u_dec (
    .op           (ifid_q.instr[31:26]),
    .ex_funct     (idex_q.funct),
    .ex_alu_class (idex_q.ctrl.alu_class),
    .ctrl         (id_ctrl),
    .alu_op       (ex_alu_op)
  );

  regfile u_rf (
    .clk(clk), .we(memwb_q.regwrite), .ra1(ifid_q.instr[25:21]), .ra2(ifid_q.instr[20:16]),
    .wa(memwb_q.writereg), .wd(wb_result), .rd1(id_rd1), .rd2(id_rd2)
  );

  always_comb
  begin
    idex_d.ctrl    = id_ctrl;
    idex_d.funct   = ifid_q.instr[5:0];
    idex_d.pcplus4 = ifid_q.pcplus4;
    idex_d.srca    = id_fwd_a ? wb_result : id_rd1;  // writeback bypass
    idex_d.srcb    = id_fwd_b ? wb_result : id_rd2;
    idex_d.imm     = {{16{ifid_q.instr[15]}}, ifid_q.instr[15:0]};
    idex_d.rs      = ifid_q.instr[25:21];
    idex_d.rt      = ifid_q.instr[20:16];
    idex_d.rd      = ifid_q.instr[15:11];
  end

  // stall drops a bubble here while ifid holds
  pipe_reg #(.payload_t(mips_pkg::idex_t)) u_idex (
    .clk(clk), .reset(reset), .hold(1'b0), .clear(stall | flush), .d(idex_d), .q(idex_q)
  );

  hazard_unit u_haz (
    .id_rs(ifid_q.instr[25:21]), .id_rt(ifid_q.instr[20:16]),
    .ex_rs(idex_q.rs), .ex_rt(idex_q.rt), .ex_memread(idex_q.ctrl.memread),
    .ex_branch_taken(ex_taken),
    .mem_rd(exmem_q.writereg), .mem_regwrite(exmem_q.regwrite),
    .wb_rd(memwb_q.writereg), .wb_regwrite(memwb_q.regwrite),
    .fwd_a(fwd_a), .fwd_b(fwd_b), .id_fwd_a(id_fwd_a), .id_fwd_b(id_fwd_b),
    .stall(stall), .flush(flush)
  );

  // ----------------------------------------------------------------------
  // execute
  // ----------------------------------------------------------------------
  always_comb
  begin
    case (fwd_a)
      mips_pkg::fwd_mem: ex_opa = exmem_q.aluout;
      mips_pkg::fwd_wb:  ex_opa = wb_result;
      default:           ex_opa = idex_q.srca;
    endcase
    case (fwd_b)
      mips_pkg::fwd_mem: ex_opb = exmem_q.aluout;
      mips_pkg::fwd_wb:  ex_opb = wb_result;
      default:           ex_opb = idex_q.srcb;
    endcase
  end

  assign ex_srcb     = idex_q.ctrl.alusrc ? idex_q.imm : ex_opb;
  assign ex_writereg = idex_q.ctrl.regdst ? idex_q.rd : idex_q.rt;
  assign ex_target   = idex_q.pcplus4 + {idex_q.imm[`MIPS_XLEN-3:0], 2'b00};
  assign ex_taken    = idex_q.ctrl.branch & (ex_zero ^ idex_q.ctrl.bne);

  alu u_alu (.a(ex_opa), .b(ex_srcb), .op(ex_alu_op), .result(ex_result), .zero(ex_zero));

  always_comb
  begin
    exmem_d.regwrite  = idex_q.ctrl.regwrite;
    exmem_d.memread   = idex_q.ctrl.memread;
    exmem_d.memwrite  = idex_q.ctrl.memwrite;
    exmem_d.memtoreg  = idex_q.ctrl.memtoreg;
    exmem_d.aluout    = ex_result;
    exmem_d.writedata = ex_opb;           // forwarded rt for sw
    exmem_d.writereg  = ex_writereg;
  end

  pipe_reg #(.payload_t(mips_pkg::exmem_t)) u_exmem (
    .clk(clk), .reset(reset), .hold(1'b0), .clear(1'b0), .d(exmem_d), .q(exmem_q)
  );

  // ----------------------------------------------------------------------
  // memory and writeback
  // ----------------------------------------------------------------------
  assign memwrite     = exmem_q.memwrite;
  assign memaddr      = exmem_q.aluout;
  assign memwritedata = exmem_q.writedata;

  always_comb
  begin
    memwb_d.regwrite = exmem_q.regwrite;
    memwb_d.memtoreg = exmem_q.memtoreg;
    memwb_d.readdata = exmem_q.memread ? memreaddata : '0;  // only loads capture
    memwb_d.aluout   = exmem_q.aluout;
    memwb_d.writereg = exmem_q.writereg;
  end

  pipe_reg #(.payload_t(mips_pkg::memwb_t)) u_memwb (
    .clk(clk), .reset(reset), .hold(1'b0), .clear(1'b0), .d(memwb_d), .q(memwb_q)
  );

  assign wb_result = memwb_q.memtoreg ? memwb_q.readdata : memwb_q.aluout;

endmodule

`default_nettype wire

/* tests/mips_sva.sv */
`timescale 1ns/1ns
`default_nettype none

`include "mips_cfg.svh"

module mips_sva (
  input logic                  clk,
  input logic                  reset,
  input logic [`MIPS_XLEN-1:0] pc,
  input logic                  memwrite,
  input logic [`MIPS_XLEN-1:0] memaddr,
  input logic [`MIPS_XLEN-1:0] memwritedata,
  input logic                  flush     // taken branch in execute
);

  // every reset edge leaves fetch at the reset pc, no store pending
  a_reset_state: assert property (@(posedge clk)
    reset |=> (!memwrite && (pc == `MIPS_RESET_PC)))
    else $error("pc or memwrite wrong after reset");

  a_pc_aligned: assert property (@(posedge clk) disable iff (reset)
    pc[1:0] == 2'b00)
    else $error("pc not word aligned");

  // store strobe carries a real address and data
  a_store_known: assert property (@(posedge clk) disable iff (reset)
    memwrite |-> !$isunknown({memaddr, memwritedata}))
    else $error("store with unknown address or data");

  // hold on a stall, step by 4, or jump right after a taken branch
  a_pc_flow: assert property (@(posedge clk) disable iff (reset)
    !$past(reset) |-> ((pc == $past(pc)) || (pc == $past(pc) + `MIPS_PC_STEP) || $past(flush)))
    else $error("pc moved without a branch");

endmodule

bind mips_pipeline mips_sva u_sva (
  .clk(clk), .reset(reset), .pc(pc), .memwrite(memwrite),
  .memaddr(memaddr), .memwritedata(memwritedata), .flush(flush)
);

`default_nettype wire

/* tests/tb_mips.sv */
`timescale 1ns/1ns
`default_nettype none

`include "mips_cfg.svh"

module tb_mips;

  logic        clk;
  logic        reset;
  logic [31:0] pc;
  logic [31:0] instr;
  logic        memwrite;
  logic [31:0] memaddr;
  logic [31:0] memwritedata;
  logic [31:0] memreaddata;

  logic [31:0] rom [0:255];               // program indexed by pc/4
  logic [31:0] dmem [0:255];              // 1 kB data memory
  logic [31:0] model_reg [0:31];          // registers as the program leaves them
  logic [31:0] model_mem [0:255];
  logic [31:0] exp_addr [$];              // expected stores in program order
  logic [31:0] exp_data [$];
  int          exp_test [$];
  string       test_name [$];

  integer      seed;
  logic [7:0]  n_instr;
  int          skip;                      // slots a taken branch still flushes
  int          cur_test;
  int          chk_idx = 0;
  int          test_errs = 0;
  int          errors = 0;
  int          tests_passed = 0;
  int          tests_failed = 0;
  int          cycles;
  int          limit;
  bit          timed_out;

  mips_pipeline i_dut (
    .clk(clk), .reset(reset), .pc(pc), .instr(instr), .memwrite(memwrite),
    .memaddr(memaddr), .memwritedata(memwritedata), .memreaddata(memreaddata)
  );

  always #50 clk = ~clk;                  // 100 ns period

  assign instr       = rom[pc[9:2]];
  assign memreaddata = dmem[memaddr[9:2]];  // same-cycle read

  always @(posedge clk)
  begin
    if (memwrite)
      dmem[memaddr[9:2]] <= memwritedata;
  end

  // ----------------------------------------------------------------------
  // program assembly with a register and memory model alongside
  // ----------------------------------------------------------------------
  function automatic logic [31:0] sext(input logic [15:0] v);
    return {{16{v[15]}}, v};
  endfunction

  task automatic put(input logic [31:0] word, output bit live);
    rom[n_instr] = word;
    n_instr      = n_instr + 8'd1;
    live         = (skip == 0);           // flushed slots change nothing
    if (skip > 0)
      skip = skip - 1;
  endtask

  task automatic pad_nops(input int n);
    bit live;
    repeat (n)
      put(32'h0000_0000, live);           // sll $0,$0,0
  endtask

  task automatic add_imm(input logic [4:0] rt, input logic [4:0] rs, input logic [15:0] imm);
    bit live;
    put({`MIPS_OP_ADDI, rs, rt, imm}, live);
    if (live && (rt != 5'd0))
      model_reg[rt] = model_reg[rs] + sext(imm);
  endtask

  task automatic rtype_op(input logic [5:0] fn, input logic [4:0] rd, input logic [4:0] rs,
                          input logic [4:0] rt);
    bit          live;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] r;
    a = model_reg[rs];
    b = model_reg[rt];
    case (fn)
      `MIPS_FN_ADD, `MIPS_FN_ADDU: r = a + b;
      `MIPS_FN_SUB, `MIPS_FN_SUBU: r = a - b;
      `MIPS_FN_AND: r = a & b;
      `MIPS_FN_OR:  r = a | b;
      `MIPS_FN_SLT: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      default:      r = (a < b) ? 32'd1 : 32'd0;  // sltu
    endcase
    put({`MIPS_OP_RTYPE, rs, rt, rd, 5'd0, fn}, live);
    if (live && (rd != 5'd0))
      model_reg[rd] = r;
  endtask

  task automatic load_word(input logic [4:0] rt, input logic [4:0] base, input logic [15:0] imm);
    bit          live;
    logic [31:0] addr;
    addr = model_reg[base] + sext(imm);
    put({`MIPS_OP_LW, base, rt, imm}, live);
    if (live && (rt != 5'd0))
      model_reg[rt] = model_mem[addr[9:2]];
  endtask

  task automatic store_word(input logic [4:0] rt, input logic [4:0] base, input logic [15:0] imm);
    bit          live;
    logic [31:0] addr;
    addr = model_reg[base] + sext(imm);
    put({`MIPS_OP_SW, base, rt, imm}, live);
    if (live)
    begin
      model_mem[addr[9:2]] = model_reg[rt];
      exp_addr.push_back(addr);
      exp_data.push_back(model_reg[rt]);
      exp_test.push_back(cur_test);
    end
  endtask

  // offset of 2 so a taken branch skips exactly the two flushed slots
  task automatic cond_branch(input bit bne, input logic [4:0] rs, input logic [4:0] rt);
    bit live;
    bit eq;
    eq = (model_reg[rs] == model_reg[rt]);
    put({(bne ? `MIPS_OP_BNE : `MIPS_OP_BEQ), rs, rt, 16'd2}, live);
    if (live && (eq ^ bne))
      skip = 2;
  endtask

  task automatic start_test(input string name);
    test_name.push_back(name);
    cur_test = test_name.size() - 1;
  endtask

  task automatic build_program();
    logic [15:0] v1, v2, v3, v4, v5;
    v1 = 16'($random(seed));
    v2 = 16'($random(seed));
    v3 = 16'($random(seed));
    v4 = 16'($random(seed));
    v5 = 16'($random(seed));
    // a negative $1 against a non-negative $2 splits slt from sltu and keeps $1 != $2
    v1[15] = 1'b1;
    v2[15] = 1'b0;
    start_test("alu ops without hazards");
    add_imm(5'd1, 5'd0, v1);
    add_imm(5'd2, 5'd0, v2);
    pad_nops(3);                          // $2 reaches the register file
    rtype_op(`MIPS_FN_ADD,  5'd3, 5'd1, 5'd2);
    rtype_op(`MIPS_FN_SUB,  5'd4, 5'd1, 5'd2);
    rtype_op(`MIPS_FN_AND,  5'd5, 5'd1, 5'd2);
    rtype_op(`MIPS_FN_OR,   5'd6, 5'd1, 5'd2);
    rtype_op(`MIPS_FN_SLT,  5'd7, 5'd1, 5'd2);
    rtype_op(`MIPS_FN_SLTU, 5'd8, 5'd1, 5'd2);
    rtype_op(`MIPS_FN_SLT,  5'd19, 5'd0, 5'd2);  // same signs take the a-b path
    for (logic [4:0] r = 5'd3; r <= 5'd8; r++)
      store_word(r, 5'd0, 16'h0100 + {9'd0, r - 5'd3, 2'b00});  // 0x100 + 4*(r-3) region
    store_word(5'd19, 5'd0, 16'h0118);
    start_test("forwarding chains");
    add_imm(5'd9, 5'd0, v3);
    rtype_op(`MIPS_FN_ADDU, 5'd10, 5'd9, 5'd1);   // memory-stage forward
    rtype_op(`MIPS_FN_SUBU, 5'd11, 5'd10, 5'd9);  // memory and writeback
    rtype_op(`MIPS_FN_OR,   5'd12, 5'd11, 5'd10);
    add_imm(5'd13, 5'd0, v4);
    pad_nops(1);
    rtype_op(`MIPS_FN_AND,  5'd14, 5'd12, 5'd13); // $12 through decode bypass
    add_imm(5'd15, 5'd14, v5);
    store_word(5'd15, 5'd0, 16'h0140);    // store data forwarded
    store_word(5'd14, 5'd0, 16'h0148);    // $14 as rt through decode bypass
    store_word(5'd11, 5'd0, 16'h0144);
    store_word(5'd12, 5'd0, 16'h014c);
    start_test("load-use stall");
    load_word(5'd16, 5'd0, 16'h0100);
    rtype_op(`MIPS_FN_ADD, 5'd17, 5'd16, 5'd2);
    store_word(5'd17, 5'd0, 16'h0180);
    load_word(5'd18, 5'd0, 16'h0104);
    store_word(5'd18, 5'd0, 16'h0184);    // loaded value as store data
    start_test("taken beq and bne");
    add_imm(5'd21, 5'd0, 16'hdead);       // marker that must never be stored
    cond_branch(1'b0, 5'd21, 5'd21);
    add_imm(5'd1, 5'd1, 16'd1);           // flushed
    store_word(5'd21, 5'd0, 16'h01c0);    // flushed
    store_word(5'd1, 5'd0, 16'h01c4);
    cond_branch(1'b1, 5'd1, 5'd2);
    store_word(5'd21, 5'd0, 16'h01d0);
    store_word(5'd21, 5'd0, 16'h01d4);
    store_word(5'd2, 5'd0, 16'h01d8);
    start_test("untaken beq and bne");
    cond_branch(1'b0, 5'd1, 5'd2);
    store_word(5'd4, 5'd0, 16'h0200);
    store_word(5'd5, 5'd0, 16'h0204);
    cond_branch(1'b1, 5'd1, 5'd1);
    store_word(5'd6, 5'd0, 16'h0208);
    store_word(5'd7, 5'd0, 16'h020c);
  endtask

  // ----------------------------------------------------------------------
  // store checker sampling outputs mid-cycle
  // ----------------------------------------------------------------------
  always @(negedge clk)
  begin
    if (!reset && memwrite)
    begin
      if (chk_idx >= exp_addr.size())
      begin
        $display("store to %h at %0t ns comes after the last expected store", memaddr, $time);
        errors++;
      end
      else
      begin
        assert (memaddr == exp_addr[chk_idx])
        else
        begin
          $display("Fail at %0t ns: memaddr is %h, expected %h",
                   $time, memaddr, exp_addr[chk_idx]);
          test_errs++;
        end
        assert (memwritedata == exp_data[chk_idx])
        else
        begin
          $display("Fail at %0t ns: memwritedata is %h, expected %h",
                   $time, memwritedata, exp_data[chk_idx]);
          test_errs++;
        end
        // last store of its test
        if ((chk_idx + 1 == exp_addr.size()) || (exp_test[chk_idx + 1] != exp_test[chk_idx]))
        begin
          $display("test %0d %s: %s", exp_test[chk_idx] + 1, test_name[exp_test[chk_idx]],
                   (test_errs == 0) ? "ok" : "failed");
          if (test_errs == 0)
            tests_passed++;
          else
            tests_failed++;
          errors    = errors + test_errs;
          test_errs = 0;
        end
        chk_idx++;
      end
    end
  end

  // ----------------------------------------------------------------------
  // main sequence
  // ----------------------------------------------------------------------
  initial
  begin
    seed      = 32'h2b65cd57;
    clk       = 1'b0;
    reset     = 1'b1;
    n_instr   = 8'd0;
    skip      = 0;
    timed_out = 1'b0;
    for (logic [5:0] i = 6'd0; i < 6'd32; i++)
      model_reg[i[4:0]] = 32'h0;
    for (logic [8:0] i = 9'd0; i < 9'd256; i++)
    begin
      dmem[i[7:0]]      = {16'hd00d, 6'd0, i[7:0], 2'b00};  // tagged by address
      model_mem[i[7:0]] = {16'hd00d, 6'd0, i[7:0], 2'b00};
      rom[i[7:0]]       = 32'h0000_0000;
    end
    build_program();
    limit = 3 * int'(n_instr) + 20;
    repeat (2) @(posedge clk);
    @(negedge clk);
    reset  = 1'b0;
    cycles = 0;
    while ((chk_idx < exp_addr.size()) && (cycles < limit))
    begin
      @(posedge clk);
      cycles++;
    end
    if (chk_idx < exp_addr.size())
    begin
      $display("timeout after %0d cycles: program never reached its final store", cycles);
      timed_out = 1'b1;
    end
    else
    begin
      repeat (4) @(posedge clk);          // a stray store would still show
    end
    $display("tests passed %0d, failed %0d, errors %0d", tests_passed, tests_failed, errors);
    if ((errors == 0) && (tests_failed == 0) && !timed_out)
      $display("Regression passed");
    else
      $display("Regression failed");
    $finish;
  end

endmodule

`default_nettype wire

/* build.f */
+incdir+include
hw/mips_pkg.sv
hw/mips_decoder.sv
hw/regfile.sv
hw/alu.sv
hw/hazard_unit.sv
hw/pipe_reg.sv
hw/mips_pipeline.sv
tests/mips_sva.sv
tests/tb_mips.sv

/* run.sh */
#!/usr/bin/env bash
# builds the mips pipeline testbench with verilator and runs it
set -e

cd "$(dirname "$0")"

log=sim.log

verilator --binary --timing --assert --timescale 1ns/1ns \
  -f build.f --top-module tb_mips -Mdir obj_dir -o vtb_mips

# an assertion stop still leaves a log to search
./obj_dir/vtb_mips | tee "$log"

if grep -q "^Regression passed$" "$log"
then
  echo "simulation PASS"
else
  echo "simulation FAIL"
  exit 1
fi
